//--- logic/st7735_pkg.sv
/* panel opcodes, wait codes, sequencer states and the word structs
   shared by the ST7735 controller */
package st7735_pkg;

   typedef enum logic [7:0] {
      SWRESET = 8'h01,
      SLPOUT  = 8'h11,
      INVCTR  = 8'hB4,
      PWCTR1  = 8'hC0,
      PWCTR4  = 8'hC3,
      PWCTR5  = 8'hC4,
      VMCTR1  = 8'hC5,
      INVOFF  = 8'h20,
      MADCTL  = 8'h36,
      COLMOD  = 8'h3A,
      CASET   = 8'h2A,
      RASET   = 8'h2B,
      NORON   = 8'h13,
      DISPON  = 8'h29,
      RAMWR   = 8'h2C
   } cmd_e;

   // wait after a script entry, in 10 ms units
   typedef enum logic [2:0] {
      WAIT_NONE,
      WAIT_10MS,
      WAIT_100MS,
      WAIT_150MS,
      WAIT_500MS
   } wait_e;

   function automatic int unsigned wait_units(wait_e w);
      case (w)
         WAIT_10MS:  return 1;
         WAIT_100MS: return 10;
         WAIT_150MS: return 15;
         WAIT_500MS: return 50;
         default:    return 0;
      endcase
   endfunction

   typedef enum logic [2:0] {
      FETCH,
      SEND,
      WAIT,
      CLEAR,
      WAIT_PIXEL,
      PIXEL
   } seq_state_e;

   typedef logic [5:0]  script_idx_t;
   typedef logic [15:0] pixel_t; // rgb565

   typedef struct packed {
      logic [7:0] value;
      logic       is_data;
      wait_e      wait_after;
   } script_entry_t;

   typedef struct packed {
      logic [15:0] data;
      logic        is_data; // level on d_c
      logic        wide;    // 16 bit word, else 8
   } spi_word_t;

   localparam int          SCRIPT_LEN = 34;
   localparam script_idx_t WINDOW_IDX = 6'd21; // CASET, frame loop restarts here
   localparam script_idx_t RAMWR_IDX  = 6'd33;

endpackage

//--- logic/init_script_rom.sv
/* init_script_rom: panel power-up script as a combinational table */
`timescale 1ns/1ns

module init_script_rom #(
   parameter int WIDTH  = 160,
   parameter int HEIGHT = 80
) (
   input  st7735_pkg::script_idx_t   script_idx,
   output st7735_pkg::script_entry_t entry
);
   import st7735_pkg::*;

   function automatic script_entry_t op(cmd_e c, wait_e w);
      return '{value: c, is_data: 1'b0, wait_after: w};
   endfunction

   function automatic script_entry_t prm(logic [7:0] v);
      return '{value: v, is_data: 1'b1, wait_after: WAIT_NONE};
   endfunction

   always_comb begin
      case (script_idx)
         6'd0:    entry = op(SWRESET, WAIT_150MS);
         6'd1:    entry = op(SLPOUT, WAIT_500MS);
         6'd2:    entry = op(INVCTR, WAIT_NONE);
         6'd3:    entry = prm(8'h07);   // normal mode
         6'd4:    entry = op(PWCTR1, WAIT_NONE);
         6'd5:    entry = prm(8'h82);
         6'd6:    entry = prm(8'h02);
         6'd7:    entry = prm(8'h84);
         6'd8:    entry = op(PWCTR4, WAIT_NONE);
         6'd9:    entry = prm(8'h8A);
         6'd10:   entry = prm(8'h2E);
         6'd11:   entry = op(PWCTR5, WAIT_NONE);
         6'd12:   entry = prm(8'h8A);
         6'd13:   entry = prm(8'hAA);
         6'd14:   entry = op(VMCTR1, WAIT_NONE);
         6'd15:   entry = prm(8'h0E);
         6'd16:   entry = op(INVOFF, WAIT_NONE);
         6'd17:   entry = op(MADCTL, WAIT_NONE);
         6'd18:   entry = prm(8'hC8);
         6'd19:   entry = op(COLMOD, WAIT_NONE);
         6'd20:   entry = prm(8'h05);   // 16 bit colour
         // columns run over the short side, visible area starts at 2
         6'd21:   entry = op(CASET, WAIT_NONE);
         6'd22:   entry = prm(8'h00);
         6'd23:   entry = prm(8'h02);
         6'd24:   entry = prm(8'h00);
         6'd25:   entry = prm(8'(HEIGHT));
         // rows start at 3
         6'd26:   entry = op(RASET, WAIT_NONE);
         6'd27:   entry = prm(8'h00);
         6'd28:   entry = prm(8'h03);
         6'd29:   entry = prm(8'h00);
         6'd30:   entry = prm(8'(WIDTH));
         6'd31:   entry = op(NORON, WAIT_10MS);
         6'd32:   entry = op(DISPON, WAIT_100MS);
         6'd33:   entry = op(RAMWR, WAIT_NONE);
         default: entry = op(RAMWR, WAIT_NONE);
      endcase
   end

endmodule

//--- logic/panel_sequencer.sv
/* panel_sequencer: script walk, wait timer, memory clear, frame loop
   and the single-entry pixel buffer */
`timescale 1ns/1ns

module panel_sequencer #(
   parameter int WIDTH          = 160,
   parameter int HEIGHT         = 80,
   parameter int MEM_SIDE       = 160,
   parameter int TICKS_PER_10MS = 120000
) (
   input  logic                      clk_main,
   input  logic                      rst_n,
   input  st7735_pkg::script_entry_t entry,
   input  logic                      word_ready,
   input  st7735_pkg::pixel_t        pixel_write,
   input  logic                      wr_en,
   output st7735_pkg::script_idx_t   script_idx,
   output st7735_pkg::spi_word_t     word,
   output logic                      word_valid,
   output logic                      buffer_free,
   output logic                      is_init
);
   import st7735_pkg::*;

   localparam int CLR_WORDS = MEM_SIDE * MEM_SIDE;
   localparam int PIX_WORDS = WIDTH * HEIGHT;
   localparam int CLR_W     = $clog2(CLR_WORDS + 1);
   localparam int PIX_W     = $clog2(PIX_WORDS + 1);
   localparam script_idx_t RASET_END = RAMWR_IDX - 6'd3; // last RASET parameter

   seq_state_e  state;
   logic [31:0] wait_cnt;
   logic [CLR_W-1:0] clear_cnt;
   logic [PIX_W-1:0] pix_cnt;
   pixel_t      pix_buf;
   script_idx_t next_idx;
   logic        accept;
   logic        take;

   assign accept = word_valid && word_ready;
   assign take   = (state == WAIT_PIXEL) && !buffer_free;

   // frames skip NORON and DISPON
   assign next_idx = (is_init && script_idx == RASET_END) ? RAMWR_IDX : script_idx + 6'd1;

   always_ff @(posedge clk_main) begin
      if (!rst_n) begin
         buffer_free <= 1'b1;
      end else if (wr_en && buffer_free) begin
         pix_buf     <= pixel_write;
         buffer_free <= 1'b0;
      end else if (take) begin
         buffer_free <= 1'b1;
      end
   end

   always_ff @(posedge clk_main) begin
      if (!rst_n) begin
         state      <= FETCH;
         script_idx <= '0;
         word_valid <= 1'b0;
         is_init    <= 1'b0;
         wait_cnt   <= '0;
         clear_cnt  <= '0;
         pix_cnt    <= '0;
      end else begin
         case (state)
            FETCH: begin
               word       <= '{data: {8'h00, entry.value}, is_data: entry.is_data, wide: 1'b0};
               word_valid <= 1'b1;
               state      <= SEND;
            end
            SEND: begin
               if (accept) begin
                  word_valid <= 1'b0;
                  if (wait_units(entry.wait_after) != 0) begin
                     wait_cnt <= 32'(wait_units(entry.wait_after) * TICKS_PER_10MS) - 32'd1;
                     state    <= WAIT;
                  end else if (script_idx == RAMWR_IDX && !is_init) begin
                     word       <= '{data: 16'h0000, is_data: 1'b1, wide: 1'b1}; // black
                     word_valid <= 1'b1;
                     clear_cnt  <= '0;
                     state      <= CLEAR;
                  end else if (script_idx == RAMWR_IDX) begin
                     pix_cnt <= '0;
                     state   <= WAIT_PIXEL;
                  end else begin
                     script_idx <= next_idx;
                     state      <= FETCH;
                  end
               end
            end
            WAIT: begin
               if (wait_cnt == 32'd0) begin
                  script_idx <= next_idx;
                  state      <= FETCH;
               end else begin
                  wait_cnt <= wait_cnt - 32'd1;
               end
            end
            CLEAR: begin
               // word_valid stays up, the shifter paces the clear
               if (accept) begin
                  if (clear_cnt == CLR_W'(CLR_WORDS - 1)) begin
                     word_valid <= 1'b0;
                     is_init    <= 1'b1;
                     script_idx <= WINDOW_IDX;
                     state      <= FETCH;
                  end else begin
                     clear_cnt <= clear_cnt + 1'b1;
                  end
               end
            end
            WAIT_PIXEL: begin
               if (take) begin
                  word       <= '{data: pix_buf, is_data: 1'b1, wide: 1'b1};
                  word_valid <= 1'b1;
                  state      <= PIXEL;
               end
            end
            PIXEL: begin
               if (accept) begin
                  word_valid <= 1'b0;
                  if (pix_cnt == PIX_W'(PIX_WORDS - 1)) begin
                     script_idx <= WINDOW_IDX; // next frame
                     state      <= FETCH;
                  end else begin
                     pix_cnt <= pix_cnt + 1'b1;
                     state   <= WAIT_PIXEL;
                  end
               end
            end
            default: state <= FETCH;
         endcase
      end
   end

   a_init_sticky: assert property (@(posedge clk_main) disable iff (!rst_n)
      is_init |=> is_init);

   a_word_held: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_valid && !word_ready |=> word_valid && $stable(word));

   a_idx_range: assert property (@(posedge clk_main) disable iff (!rst_n)
      script_idx < SCRIPT_LEN);

endmodule

//--- logic/spi_word_shifter.sv
/* spi_word_shifter: serialises 8 or 16 bit words, msb first, with a
   divided clock that idles high */
`timescale 1ns/1ns

module spi_word_shifter #(
   parameter int SCLK_HALF_CYCLES = 1
) (
   input  logic                  clk_main,
   input  logic                  rst_n,
   input  st7735_pkg::spi_word_t word,
   input  logic                  word_valid,
   output logic                  word_ready,
   output logic                  spi_clk,
   output logic                  spi_mosi,
   output logic                  spi_d_c,
   output logic                  spi_ss
);
   import st7735_pkg::*;

   localparam int DIV_W = (SCLK_HALF_CYCLES > 1) ? $clog2(SCLK_HALF_CYCLES) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       bit_cnt;  // bits left after the current one
   logic [15:0]      shreg;
   logic [15:0]      aligned;
   logic             busy;
   logic             accept;
   logic             half_done;

   assign accept    = word_valid && word_ready;
   assign half_done = (div_cnt == DIV_W'(SCLK_HALF_CYCLES - 1));
   assign aligned   = word.wide ? word.data : {word.data[7:0], 8'h00}; // byte goes out on top

   always_ff @(posedge clk_main) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         word_ready <= 1'b0;
         spi_ss     <= 1'b1;
         spi_clk    <= 1'b1;
         spi_mosi   <= 1'b0;
         spi_d_c    <= 1'b1;
         div_cnt    <= '0;
         bit_cnt    <= '0;
      end else if (accept) begin
         busy       <= 1'b1;
         word_ready <= 1'b0;
         spi_ss     <= 1'b0;
         spi_clk    <= 1'b0;       // first falling edge puts out the msb
         spi_mosi   <= aligned[15];
         spi_d_c    <= word.is_data;
         div_cnt    <= '0;
         bit_cnt    <= word.wide ? 4'd15 : 4'd7;
      end else if (busy) begin
         if (half_done) begin
            div_cnt <= '0;
            if (!spi_clk) begin
               spi_clk <= 1'b1;    // panel samples here
            end else if (bit_cnt == 4'd0) begin
               busy   <= 1'b0;
               spi_ss <= 1'b1;
            end else begin
               spi_clk  <= 1'b0;
               spi_mosi <= shreg[14];
               bit_cnt  <= bit_cnt - 4'd1;
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end else begin
         word_ready <= 1'b1;       // one idle cycle with ss high
      end
   end

   always_ff @(posedge clk_main) begin
      if (accept) begin
         shreg <= aligned;
      end else if (busy && half_done && spi_clk && bit_cnt != 4'd0) begin
         shreg <= {shreg[14:0], 1'b0};
      end
   end

   a_clk_framed: assert property (@(posedge clk_main) disable iff (!rst_n)
      $changed(spi_clk) |-> !spi_ss);

   a_no_overlap: assert property (@(posedge clk_main) disable iff (!rst_n)
      accept |=> (!word_ready until_with spi_ss));

endmodule

//--- logic/st7735_top.sv
/* st7735_top: script table, sequencer and SPI shifter for the
   ST7735 panel controller */
`timescale 1ns/1ns

module st7735_top #(
   parameter int WIDTH            = 160,
   parameter int HEIGHT           = 80,
   parameter int MEM_SIDE         = 160,
   parameter int TICKS_PER_10MS   = 120000,
   parameter int SCLK_HALF_CYCLES = 1
) (
   input  logic               clk_main,
   input  logic               rst_n,
   input  st7735_pkg::pixel_t pixel_write,
   input  logic               wr_en,
   output logic               buffer_free,
   output logic               is_init,
   output logic               spi_clk,
   output logic               spi_mosi,
   output logic               spi_d_c,
   output logic               spi_ss
);
   import st7735_pkg::*;

   script_idx_t   script_idx;
   script_entry_t entry;
   spi_word_t     word;
   logic          word_valid;
   logic          word_ready;

   init_script_rom #(
      .WIDTH (WIDTH),
      .HEIGHT(HEIGHT)
   ) u_rom (
      .script_idx(script_idx),
      .entry     (entry)
   );

   panel_sequencer #(
      .WIDTH         (WIDTH),
      .HEIGHT        (HEIGHT),
      .MEM_SIDE      (MEM_SIDE),
      .TICKS_PER_10MS(TICKS_PER_10MS)
   ) u_seq (
      .clk_main   (clk_main),
      .rst_n      (rst_n),
      .entry      (entry),
      .word_ready (word_ready),
      .pixel_write(pixel_write),
      .wr_en      (wr_en),
      .script_idx (script_idx),
      .word       (word),
      .word_valid (word_valid),
      .buffer_free(buffer_free),
      .is_init    (is_init)
   );

   spi_word_shifter #(
      .SCLK_HALF_CYCLES(SCLK_HALF_CYCLES)
   ) u_spi (
      .clk_main  (clk_main),
      .rst_n     (rst_n),
      .word      (word),
      .word_valid(word_valid),
      .word_ready(word_ready),
      .spi_clk   (spi_clk),
      .spi_mosi  (spi_mosi),
      .spi_d_c   (spi_d_c),
      .spi_ss    (spi_ss)
   );

endmodule

//--- verif/tb_spi_monitor.sv
/* rebuilds SPI words from the panel pins and checks them against
   the expected init, clear and frame stream */
`timescale 1ns/1ns

module tb_spi_monitor #(
   parameter int WIDTH  = 4,
   parameter int HEIGHT = 3
) (
   input  logic clk_main,
   input  logic rst_n,
   input  logic spi_clk,
   input  logic spi_mosi,
   input  logic spi_d_c,
   input  logic spi_ss,
   input  logic is_init,
   output logic done
);
   localparam int SCRIPT_WORDS = 34;
   localparam int CLEAR_END    = 43;   // script plus 3x3 clear words
   localparam int FRAME_WORDS  = 11 + WIDTH * HEIGHT;
   localparam int LAST_WORD    = CLEAR_END + 2 * FRAME_WORDS;

   logic [7:0]  script_val [0:33];
   logic [15:0] pix_mem [0:255];
   int          pix_wr;
   int          errs [0:5];
   int          tests_run;
   int          tests_failed;

   logic [15:0] got_val;
   logic        got_dc;
   int          got_bits;
   int          word_idx;
   int          cyc;
   int          last_fall;
   logic        ss_q;
   logic        clk_q;
   logic        ss_fall;
   logic        word_done;
   logic        word_done_q;

   initial begin
      script_val = '{8'h01, 8'h11, 8'hB4, 8'h07, 8'hC0, 8'h82, 8'h02, 8'h84,
                     8'hC3, 8'h8A, 8'h2E, 8'hC4, 8'h8A, 8'hAA, 8'hC5, 8'h0E,
                     8'h20, 8'h36, 8'hC8, 8'h3A, 8'h05,
                     8'h2A, 8'h00, 8'h02, 8'h00, 8'(HEIGHT),
                     8'h2B, 8'h00, 8'h03, 8'h00, 8'(WIDTH),
                     8'h13, 8'h29, 8'h2C};
      pix_wr       = 0;
      tests_run    = 0;
      tests_failed = 0;
      foreach (errs[i]) errs[i] = 0;
   end

   task automatic push_pixel(input logic [15:0] v);
      pix_mem[pix_wr] = v;
      pix_wr++;
   endtask

   task automatic note_fail(input int cat, input string msg);
      $display("FAIL %0t: %s", $time, msg);
      errs[cat]++;
   endtask

   task automatic report(input int cat, input string name);
      tests_run++;
      if (errs[cat] == 0) begin
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail with %0d errors", name, errs[cat]);
      end
   endtask

   function automatic int frame_pos(int idx);
      return (idx - CLEAR_END) % FRAME_WORDS;
   endfunction

   function automatic logic is_cmd(int idx);
      return idx inside {0, 1, 2, 4, 8, 11, 14, 16, 17, 19, 21, 26, 31, 32, 33};
   endfunction

   function automatic int exp_bits(int idx);
      if (idx < SCRIPT_WORDS) return 8;
      if (idx < CLEAR_END) return 16;
      return (frame_pos(idx) < 11) ? 8 : 16;
   endfunction

   function automatic logic exp_dc(int idx);
      int m;
      m = frame_pos(idx);
      if (idx < SCRIPT_WORDS) return !is_cmd(idx);
      if (idx < CLEAR_END) return 1'b1;
      if (m < 11) return !is_cmd(21 + ((m == 10) ? 12 : m));
      return 1'b1;
   endfunction

   function automatic logic [15:0] exp_val(int idx);
      int m;
      m = frame_pos(idx);
      if (idx < SCRIPT_WORDS) return {8'h00, script_val[idx]};
      if (idx < CLEAR_END) return 16'h0000;   // black
      if (m < 10) return {8'h00, script_val[21 + m]};
      if (m == 10) return 16'h002C;
      return pix_mem[((idx - CLEAR_END) / FRAME_WORDS) * WIDTH * HEIGHT + m - 11];
   endfunction

   // minimum start-to-start spacing in cycles (wait units times 4 ticks)
   function automatic int min_gap(int idx);
      case (idx)
         1:  return 15 * 4;
         2:  return 50 * 4;
         32: return 1 * 4;
         33: return 10 * 4;
         default: return 0;
      endcase
   endfunction

   assign ss_fall   = !spi_ss && ss_q;
   assign word_done = spi_ss && !ss_q;

   always_ff @(posedge clk_main) begin
      if (!rst_n) begin
         ss_q        <= 1'b1;
         clk_q       <= 1'b1;
         cyc         <= 0;
         last_fall   <= 0;
         word_idx    <= 0;
         got_bits    <= 0;
         got_val     <= '0;
         got_dc      <= 1'b0;
         word_done_q <= 1'b0;
         done        <= 1'b0;
      end else begin
         ss_q        <= spi_ss;
         clk_q       <= spi_clk;
         cyc         <= cyc + 1;
         word_done_q <= word_done;
         if (ss_fall) begin
            last_fall <= cyc;
            got_bits  <= 0;
            got_val   <= '0;
         end else if (spi_clk && !clk_q && !spi_ss) begin
            got_val  <= {got_val[14:0], spi_mosi};   // msb first
            got_dc   <= spi_d_c;
            got_bits <= got_bits + 1;
         end
         if (word_done) word_idx <= word_idx + 1;
         // test lines follow one cycle after the word that ends them
         if (word_done_q) begin
            if (word_idx == SCRIPT_WORDS) begin
               report(1, "init_script");
               report(2, "waits");
            end
            if (word_idx == CLEAR_END) report(3, "memory_clear");
            if (word_idx == LAST_WORD) begin
               report(4, "frame_stream");
               done <= 1'b1;
            end
         end
      end
   end

   a_bits: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_done |-> got_bits == exp_bits(word_idx))
      else note_fail((word_idx < SCRIPT_WORDS) ? 1 : (word_idx < CLEAR_END) ? 3 : 4,
                     $sformatf("word %0d has %0d bits", word_idx, got_bits));

   a_value: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_done |-> got_val == exp_val(word_idx))
      else note_fail((word_idx < SCRIPT_WORDS) ? 1 : (word_idx < CLEAR_END) ? 3 : 4,
                     $sformatf("word %0d is %h, expected %h", word_idx, got_val,
                               exp_val(word_idx)));

   a_dc: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_done |-> got_dc == exp_dc(word_idx))
      else note_fail((word_idx < SCRIPT_WORDS) ? 1 : (word_idx < CLEAR_END) ? 3 : 4,
                     $sformatf("word %0d has d_c %b", word_idx, got_dc));

   a_wait: assert property (@(posedge clk_main) disable iff (!rst_n)
      ss_fall |-> (cyc - last_fall) >= min_gap(word_idx))
      else note_fail(2, $sformatf("word %0d started %0d cycles after the previous one",
                                  word_idx, cyc - last_fall));

   a_init_low: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_idx < CLEAR_END - 1 |-> !is_init)
      else note_fail(3, "is_init high before the last clear word");

   a_init_high: assert property (@(posedge clk_main) disable iff (!rst_n)
      word_idx >= CLEAR_END |-> is_init)
      else note_fail(3, "is_init low after the memory clear");

endmodule

//--- verif/tb_top.sv
/* clock, reset, DUT, random pixel writer, timeout and the
   closing report */
`timescale 1ns/1ns

module tb_top;
   localparam int WIDTH  = 4;
   localparam int HEIGHT = 3;
   // twice the cycles for init, clear and two frames at SCLK_HALF_CYCLES 2
   localparam int LIMIT  = 2 * (4 * 76 + 56 * 34 + 33 * 66 + 24 * 8);

   logic        clk_main;
   logic        rst_n;
   logic [15:0] pixel_write;
   logic        wr_en;
   logic        buffer_free;
   logic        is_init;
   logic        spi_clk;
   logic        spi_mosi;
   logic        spi_d_c;
   logic        spi_ss;
   logic        done;
   int          cyc;
   logic        timed_out;

   st7735_top #(
      .WIDTH           (WIDTH),
      .HEIGHT          (HEIGHT),
      .MEM_SIDE        (3),
      .TICKS_PER_10MS  (4),
      .SCLK_HALF_CYCLES(2)
   ) DUT (
      .clk_main   (clk_main),
      .rst_n      (rst_n),
      .pixel_write(pixel_write),
      .wr_en      (wr_en),
      .buffer_free(buffer_free),
      .is_init    (is_init),
      .spi_clk    (spi_clk),
      .spi_mosi   (spi_mosi),
      .spi_d_c    (spi_d_c),
      .spi_ss     (spi_ss)
   );

   tb_spi_monitor #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) MON (
      .clk_main(clk_main),
      .rst_n   (rst_n),
      .spi_clk (spi_clk),
      .spi_mosi(spi_mosi),
      .spi_d_c (spi_d_c),
      .spi_ss  (spi_ss),
      .is_init (is_init),
      .done    (done)
   );

   always #5 clk_main = ~clk_main;

   always @(posedge clk_main) cyc <= cyc + 1;

   // edges 2 to 6 sample the outputs during and just after reset
   a_reset: assert property (@(posedge clk_main)
      (cyc >= 1 && cyc <= 5) |-> spi_ss && spi_clk && spi_d_c && !is_init && buffer_free)
      else MON.note_fail(0, "outputs not at their reset values");

   a_full: assert property (@(posedge clk_main) disable iff (!rst_n)
      wr_en && buffer_free |=> !buffer_free)
      else MON.note_fail(5, "buffer_free still high after an accepted write");

   initial begin : pixel_writer
      int          opp;
      logic        tried;
      logic [15:0] v;
      void'($urandom(32'h8494));
      opp   = 0;
      tried = 1'b0;
      @(posedge clk_main iff rst_n);
      forever begin
         @(posedge clk_main);
         if (buffer_free && !wr_en) begin
            opp++;
            if (opp % 3 != 0) begin   // every third chance left idle
               v = 16'($urandom);
               wr_en       <= 1'b1;
               pixel_write <= v;
               MON.push_pixel(v);
            end
         end else if (!buffer_free && !wr_en && !is_init && !tried) begin
            // buffer is full during init so this write must be dropped
            wr_en       <= 1'b1;
            pixel_write <= 16'hDEAD;
            tried = 1'b1;
         end else begin
            wr_en <= 1'b0;
         end
      end
   end

   initial begin
      int total;
      clk_main    = 1'b0;
      rst_n       = 1'b0;
      wr_en       = 1'b0;
      pixel_write = '0;
      cyc         = 0;
      timed_out   = 1'b0;
      repeat (5) @(posedge clk_main);
      rst_n <= 1'b1;
      while (!done && !timed_out) begin
         @(posedge clk_main);
         if (cyc == 7) MON.report(0, "reset_state");
         if (cyc >= LIMIT) timed_out = 1'b1;
      end
      MON.report(5, "pixel_handshake");
      total = 0;
      foreach (MON.errs[i]) total += MON.errs[i];
      if (timed_out) $display("run stopped: no second frame after %0d cycles", LIMIT);
      $display("tests: %0d run, %0d failed, %0d errors", MON.tests_run, MON.tests_failed,
               total);
      if (timed_out || total != 0) begin
         $display("Simulation failed");
      end else begin
         $display("Simulation passed");
      end
      $finish;
   end

endmodule

//--- filelist.f
logic/st7735_pkg.sv
logic/init_script_rom.sv
logic/panel_sequencer.sv
logic/spi_word_shifter.sv
logic/st7735_top.sv
verif/tb_spi_monitor.sv
verif/tb_top.sv
